// File: hdl/lumi_tx_consts.svh
/* Link transmit widths, byte counts, UMI opcode codes
   and credit-update message codes */
`ifndef LUMI_TX_CONSTS_SVH
`define LUMI_TX_CONSTS_SVH

// Bus and field widths in bits
`define LUMI_IOW             64     // PHY bus, 8 byte lanes max
`define LUMI_DW              128
`define LUMI_AW              64
`define LUMI_CW              32
`define LUMI_CRDTW           16     // Credit and stall counters
`define LUMI_LENW            12     // Byte or line counts

// Packet byte counts
`define LUMI_CMD_BYTES       (`LUMI_CW/8)                    // 4
`define LUMI_HDR_BYTES       ((`LUMI_CW+2*`LUMI_AW)/8)       // 20, cmd plus both addresses
`define LUMI_PKT_BYTES       (`LUMI_HDR_BYTES+`LUMI_DW/8)    // 36
`define LUMI_MAX_DATA_BYTES  16     // Data part never longer than this

// Low command byte, size bits included
`define LUMI_OP_INVALID      8'h00
`define LUMI_OP_REQ_READ     8'h01
`define LUMI_OP_REQ_WRITE    8'h03
`define LUMI_OP_REQ_POSTED   8'h05
`define LUMI_OP_REQ_RDMA     8'h07
`define LUMI_OP_REQ_ATOMIC   8'h09
`define LUMI_OP_REQ_USER0    8'h0B
`define LUMI_OP_REQ_FUTURE0  8'h0D
`define LUMI_OP_REQ_ERROR    8'h0F
`define LUMI_OP_REQ_LINK     8'h2F  // Error opcode with size 1
`define LUMI_OP_RESP_READ    8'h02
`define LUMI_OP_RESP_WRITE   8'h04
`define LUMI_OP_RESP_LINK    8'h0E

// Credit-update message
`define LUMI_CRDT_SUBTYPE    4'h2
`define LUMI_CRDT_OPCODE     8'h2F

`endif

// File: hdl/lumi_tx_pkg.sv
/* Shared types of the link transmitter: command word union,
   UMI packet, CSR block, credit pair and serializer load record */
`include "lumi_tx_consts.svh"

package lumi_tx_pkg;

   //##########################################################################
   // Command word, one 32-bit word read two ways
   //##########################################################################

   // Normal UMI command
   typedef struct packed {
      logic [15:0] other;      // Qos, prot, eom etc, not used here
      logic [7:0]  len;        // Transfers minus one
      logic [2:0]  size;       // log2 bytes per transfer
      logic [4:0]  opcode;
   } umi_view_t;

   // Link-layer message, credit updates
   typedef struct packed {
      logic [15:0] crdt;       // Credit value
      logic [3:0]  ctype;      // 0 request, 1 response
      logic [3:0]  subtype;
      logic [7:0]  opcode;     // Whole low byte
   } link_view_t;

   typedef union packed {
      umi_view_t  umi;
      link_view_t link;
   } umi_cmd_u;

   //##########################################################################
   // Packet and control records
   //##########################################################################

   // Full packet, cmd at the lsb end so it goes out first
   typedef struct packed {
      logic [`LUMI_DW-1:0] data;
      logic [`LUMI_AW-1:0] srcaddr;
      logic [`LUMI_AW-1:0] dstaddr;
      umi_cmd_u            cmd;
   } umi_pkt_t;

   typedef struct packed {
      logic                   en;           // Transmit enable
      logic                   crdt_en;      // Periodic credit updates
      logic [1:0]             iowidth;      // log2 bytes per beat
      logic [`LUMI_CRDTW-1:0] crdt_intrvl;  // Update period in cycles
   } lumi_csr_t;

   typedef struct packed {
      logic [`LUMI_CRDTW-1:0] req;
      logic [`LUMI_CRDTW-1:0] resp;
   } lumi_crdt_t;

   // Handed from arbiter to serializer
   typedef struct packed {
      umi_pkt_t              pkt;
      logic [`LUMI_LENW-1:0] bytes;  // Trimmed length
      logic [1:0]            kind;   // One-hot req/resp, zero for credit msg
   } lumi_load_t;

endpackage

// File: hdl/lumi_pkt_size.sv
/* Opcode classing, trimmed packet length and credit need */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module lumi_pkt_size
  (
   input  lumi_tx_pkg::umi_cmd_u    cmd,
   input  logic [1:0]               iowidth,    // log2 bytes per beat
   output logic [`LUMI_LENW-1:0]    bytes,      // Bytes on the wire
   output logic [`LUMI_CRDTW-1:0]   crdt_need   // Beats, rounded up
   );

   logic [7:0]              op;          // Opcode, size bits cleared
   logic                    hdr_only;
   logic                    no_data;
   logic [15:0]             data_raw;    // (len+1) << size, uncapped
   logic [`LUMI_LENW-1:0]   data_bytes;
   logic [`LUMI_CRDTW-1:0]  beat_bytes;

   assign op = {3'b000, cmd.umi.opcode};

   // Classing
   always_comb
   begin
      hdr_only = 1'b0;
      no_data  = 1'b0;
      case (op)
         `LUMI_OP_INVALID,
         `LUMI_OP_RESP_LINK   : hdr_only = 1'b1;
         `LUMI_OP_REQ_READ,
         `LUMI_OP_REQ_RDMA,
         `LUMI_OP_RESP_WRITE,
         `LUMI_OP_REQ_USER0,
         `LUMI_OP_REQ_FUTURE0 : no_data = 1'b1;
         `LUMI_OP_REQ_ERROR   :
         begin
            // Same opcode, link message told apart by size
            if (cmd.link.opcode == `LUMI_OP_REQ_LINK)
               hdr_only = 1'b1;
            else
               no_data = 1'b1;
         end
         default              : ;   // Carries data
      endcase
   end

   // Data part, capped at 16 bytes
   assign data_raw   = (16'(cmd.umi.len) + 16'd1) << cmd.umi.size;
   assign data_bytes = (data_raw > 16'(`LUMI_MAX_DATA_BYTES)) ?
                       `LUMI_LENW'(`LUMI_MAX_DATA_BYTES) : data_raw[`LUMI_LENW-1:0];

   assign bytes = hdr_only ? `LUMI_LENW'(`LUMI_CMD_BYTES) :
                  no_data  ? `LUMI_LENW'(`LUMI_HDR_BYTES) :
                             `LUMI_LENW'(`LUMI_HDR_BYTES) + data_bytes;

   // Ceil(bytes / W)
   assign beat_bytes = `LUMI_CRDTW'(1) << iowidth;
   assign crdt_need  = (`LUMI_CRDTW'(bytes) + beat_bytes - `LUMI_CRDTW'(1)) >> iowidth;

endmodule

// File: hdl/lumi_crdt_update.sv
/* Credit-update interval timer and two-step message sequencer */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module lumi_crdt_update
  (
   input  logic                    clk,
   input  logic                    nreset,
   input  lumi_tx_pkg::lumi_csr_t  csr,
   input  lumi_tx_pkg::lumi_crdt_t loc_crdt,     // Local counts to advertise
   input  logic                    msg_taken,    // Message loaded this cycle
   output logic                    msg_pending,
   output lumi_tx_pkg::umi_cmd_u   msg_cmd
   );

   logic [`LUMI_CRDTW-1:0] timer;
   logic                   wrap;
   logic [1:0]             step;    // 01 response count, 10 request count

   assign wrap = csr.crdt_en & (timer == csr.crdt_intrvl);

   // Interval timer, frozen while updates are off
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         timer <= '0;
      else if (csr.crdt_en)
         timer <= wrap ? '0 : timer + 1'b1;

   // Response first, then request, then idle
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         step <= 2'b00;
      else if (wrap)
         step <= 2'b01;
      else if (msg_taken)
         step <= {step[0], 1'b0};

   assign msg_pending = |step;

   // Link view of the command word
   always_comb
   begin
      msg_cmd.link.crdt    = step[0] ? loc_crdt.resp : loc_crdt.req;
      msg_cmd.link.ctype   = {3'b000, step[0]};   // 1 response
      msg_cmd.link.subtype = `LUMI_CRDT_SUBTYPE;
      msg_cmd.link.opcode  = `LUMI_CRDT_OPCODE;
   end

endmodule

// File: hdl/lumi_crdt_track.sv
/* Remote credit accounting per channel and credit stall counters */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module lumi_crdt_track
  (
   input  logic                    clk,
   input  logic                    nreset,
   input  lumi_tx_pkg::lumi_crdt_t rmt_crdt,    // Total granted by remote
   input  logic [`LUMI_CRDTW-1:0]  req_need,
   input  logic [`LUMI_CRDTW-1:0]  resp_need,
   input  logic [1:0]              beat_kind,   // Type of beat on the PHY
   input  logic                    beat_done,   // Beat transfers this cycle
   input  logic                    req_valid,
   input  logic                    resp_valid,
   input  logic                    phy_txrdy,
   output logic                    req_ok,
   output logic                    resp_ok,
   output logic [31:0]             crdt_status  // resp stalls : req stalls
   );

   logic [`LUMI_CRDTW-1:0] used_req;    // Beats sent so far
   logic [`LUMI_CRDTW-1:0] used_resp;
   logic                   req_beat;    // Beat of this type going now
   logic                   resp_beat;
   logic [`LUMI_CRDTW-1:0] avail_req;
   logic [`LUMI_CRDTW-1:0] avail_resp;

   assign req_beat  = beat_done & beat_kind[0];
   assign resp_beat = beat_done & beat_kind[1];

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         used_req  <= '0;
         used_resp <= '0;
      end
      else
      begin
         used_req  <= used_req  + `LUMI_CRDTW'(req_beat);
         used_resp <= used_resp + `LUMI_CRDTW'(resp_beat);
      end

   // Grant left, counting the beat leaving right now
   assign avail_req  = rmt_crdt.req  - used_req  - `LUMI_CRDTW'(req_beat);
   assign avail_resp = rmt_crdt.resp - used_resp - `LUMI_CRDTW'(resp_beat);

   assign req_ok  = avail_req  >= req_need;
   assign resp_ok = avail_resp >= resp_need;

   //##########################################################################
   // Stall counters, cycles waiting on the remote side only
   //##########################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         crdt_status <= '0;
      else
      begin
         crdt_status[15:0]  <= crdt_status[15:0]  + 16'(req_valid  & phy_txrdy & ~req_ok);
         crdt_status[31:16] <= crdt_status[31:16] + 16'(resp_valid & phy_txrdy & ~resp_ok);
      end

endmodule

// File: hdl/lumi_tx_arbiter.sv
/* Channel gating, response-over-request priority, ready and load
   strobe generation, selected packet record */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module lumi_tx_arbiter
  (
   input  logic                   req_valid,
   input  logic                   resp_valid,
   input  lumi_tx_pkg::umi_pkt_t  req_pkt,
   input  lumi_tx_pkg::umi_pkt_t  resp_pkt,
   output logic                   req_ready,
   output logic                   resp_ready,
   input  logic [`LUMI_LENW-1:0]  req_bytes,
   input  logic [`LUMI_LENW-1:0]  resp_bytes,
   input  logic                   req_ok,       // Enough remote credit
   input  logic                   resp_ok,
   input  logic                   csr_en,
   input  logic                   msg_pending,  // Credit update waiting
   input  lumi_tx_pkg::umi_cmd_u  msg_cmd,
   input  logic                   can_load,     // Serializer free next cycle
   input  logic                   phy_txrdy,
   output logic                   load,
   output lumi_tx_pkg::lumi_load_t load_pkt,
   output logic                   msg_taken
   );

   logic slot;      // A packet may enter the serializer now
   logic req_go;    // Channel eligible
   logic resp_go;
   logic req_win;   // Request only wins when no response

   assign slot = can_load & phy_txrdy & csr_en;

   // Credit message blocks both channels
   assign resp_go = resp_valid & resp_ok & csr_en & ~msg_pending;
   assign req_go  = req_valid  & req_ok  & csr_en & ~msg_pending;
   assign req_win = req_go & ~resp_go;

   assign resp_ready = resp_go & slot;
   assign req_ready  = req_win & slot;
   assign msg_taken  = msg_pending & slot;
   assign load       = slot & (msg_pending | resp_go | req_go);

   //##########################################################################
   // Selected packet
   //##########################################################################
   always_comb
   begin
      load_pkt = '0;
      if (msg_pending)
      begin
         load_pkt.pkt.cmd = msg_cmd;                    // Upper bytes stay zero
         load_pkt.bytes   = `LUMI_LENW'(`LUMI_CMD_BYTES);
         load_pkt.kind    = 2'b00;                      // Not counted
      end
      else if (resp_go)
      begin
         load_pkt.pkt   = resp_pkt;
         load_pkt.bytes = resp_bytes;
         load_pkt.kind  = 2'b10;
      end
      else
      begin
         load_pkt.pkt   = req_pkt;
         load_pkt.bytes = req_bytes;
         load_pkt.kind  = 2'b01;
      end
   end

endmodule

// File: hdl/lumi_tx_serializer.sv
/* Packet shift register, remaining byte count and PHY beat outputs */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module lumi_tx_serializer
  (
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    load,
   input  lumi_tx_pkg::lumi_load_t load_pkt,
   input  logic [1:0]              iowidth,     // log2 bytes per beat
   input  logic                    phy_txrdy,
   output logic                    can_load,    // Empty or on the last beat
   output logic                    beat_done,
   output logic [1:0]              beat_kind,
   output logic [`LUMI_IOW-1:0]    phy_txdata,
   output logic                    phy_txvld
   );

   logic [`LUMI_PKT_BYTES*8-1:0] shreg;       // Lsb goes out first
   logic [`LUMI_LENW-1:0]        rem;         // Bytes still to send
   logic [1:0]                   kind;
   logic [`LUMI_LENW-1:0]        wbytes;      // W
   logic [6:0]                   wbits;       // 8*W, up to 64
   logic                         last;
   logic [`LUMI_IOW-1:0]         lane_mask;

   assign wbytes = `LUMI_LENW'(1) << iowidth;
   assign wbits  = 7'd8 << iowidth;
   assign last   = rem <= wbytes;

   assign can_load  = last;              // Also true when rem is zero
   assign phy_txvld = |rem;
   assign beat_done = phy_txvld & phy_txrdy;
   assign beat_kind = kind;

   //##########################################################################
   // Remaining count and packet type
   //##########################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         rem  <= '0;
         kind <= 2'b00;
      end
      else if (load)
      begin
         rem  <= load_pkt.bytes;
         kind <= load_pkt.kind;
      end
      else if (beat_done)
         rem <= last ? '0 : rem - wbytes;

   // Payload, no reset
   always_ff @(posedge clk)
      if (load)
         shreg <= load_pkt.pkt;
      else if (beat_done)
         shreg <= shreg >> wbits;

   //##########################################################################
   // PHY lanes
   //##########################################################################
   assign lane_mask = ~({`LUMI_IOW{1'b1}} << wbits);   // All ones at W = 8

   // Idle bus driven low
   assign phy_txdata = phy_txvld ? (shreg[`LUMI_IOW-1:0] & lane_mask) : '0;

endmodule

// File: hdl/lumi_tx.sv
/* Link transmitter top: sizing, credit update and tracking,
   arbitration and serializer */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module lumi_tx
  (
   input  logic                    clk,
   input  logic                    nreset,
   input  lumi_tx_pkg::lumi_csr_t  csr,
   // UMI channels
   input  logic                    req_valid,
   input  logic                    resp_valid,
   input  lumi_tx_pkg::umi_pkt_t   req_pkt,
   input  lumi_tx_pkg::umi_pkt_t   resp_pkt,
   output logic                    req_ready,
   output logic                    resp_ready,
   // Credits
   input  lumi_tx_pkg::lumi_crdt_t rmt_crdt,
   input  lumi_tx_pkg::lumi_crdt_t loc_crdt,
   output logic [31:0]             csr_crdt_status,
   // PHY
   output logic [`LUMI_IOW-1:0]    phy_txdata,
   output logic                    phy_txvld,
   input  logic                    phy_txrdy
   );

   import lumi_tx_pkg::*;

   logic [`LUMI_LENW-1:0]  req_bytes;
   logic [`LUMI_LENW-1:0]  resp_bytes;
   logic [`LUMI_CRDTW-1:0] req_need;
   logic [`LUMI_CRDTW-1:0] resp_need;
   logic                   req_ok;
   logic                   resp_ok;
   logic                   msg_pending;
   logic                   msg_taken;
   umi_cmd_u               msg_cmd;
   logic                   can_load;
   logic                   load;
   lumi_load_t             load_pkt;
   logic                   beat_done;
   logic [1:0]             beat_kind;

   // One sizer per channel
   lumi_pkt_size u_size_req
     (.cmd(req_pkt.cmd), .iowidth(csr.iowidth), .bytes(req_bytes), .crdt_need(req_need));

   lumi_pkt_size u_size_resp
     (.cmd(resp_pkt.cmd), .iowidth(csr.iowidth), .bytes(resp_bytes), .crdt_need(resp_need));

   lumi_crdt_update u_crdt_update
     (.clk(clk), .nreset(nreset), .csr(csr), .loc_crdt(loc_crdt),
      .msg_taken(msg_taken), .msg_pending(msg_pending), .msg_cmd(msg_cmd));

   lumi_crdt_track u_crdt_track
     (.clk(clk), .nreset(nreset), .rmt_crdt(rmt_crdt),
      .req_need(req_need), .resp_need(resp_need),
      .beat_kind(beat_kind), .beat_done(beat_done),
      .req_valid(req_valid), .resp_valid(resp_valid), .phy_txrdy(phy_txrdy),
      .req_ok(req_ok), .resp_ok(resp_ok), .crdt_status(csr_crdt_status));

   lumi_tx_arbiter u_arbiter
     (.req_valid(req_valid), .resp_valid(resp_valid),
      .req_pkt(req_pkt), .resp_pkt(resp_pkt),
      .req_ready(req_ready), .resp_ready(resp_ready),
      .req_bytes(req_bytes), .resp_bytes(resp_bytes),
      .req_ok(req_ok), .resp_ok(resp_ok), .csr_en(csr.en),
      .msg_pending(msg_pending), .msg_cmd(msg_cmd),
      .can_load(can_load), .phy_txrdy(phy_txrdy),
      .load(load), .load_pkt(load_pkt), .msg_taken(msg_taken));

   lumi_tx_serializer u_serializer
     (.clk(clk), .nreset(nreset), .load(load), .load_pkt(load_pkt),
      .iowidth(csr.iowidth), .phy_txrdy(phy_txrdy), .can_load(can_load),
      .beat_done(beat_done), .beat_kind(beat_kind),
      .phy_txdata(phy_txdata), .phy_txvld(phy_txvld));

endmodule

// File: verif/tb_clkgen.sv
/* Testbench clock and reset source */
`timescale 1ns/1ps

module tb_clkgen
  #(parameter int PERIOD       = 4,   // ns
    parameter int RESET_CYCLES = 4)
  (
   output logic clk,
   output logic nreset
   );

   initial clk = 1'b0;
   always #(PERIOD/2) clk = ~clk;

   initial
   begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk) nreset = 1'b1;   // Release away from the active edge
   end

endmodule

// File: verif/tb_lumi_tx.sv
/* Link transmitter testbench: PHY monitor, beat model from the packet
   rules, directed tests and watchdog */
`timescale 1ns/1ps
`include "lumi_tx_consts.svh"

module tb_lumi_tx;
   import lumi_tx_pkg::*;

   localparam int PKTW   = `LUMI_PKT_BYTES*8;
   localparam int CLK_NS = 4;
   // Class sweep is 12 runs of up to ~100 cycles at W=1, other tests far less
   localparam int BUDGET_CYCLES = 12*250 + 4*500;

   logic                   clk;
   logic                   nreset;
   lumi_csr_t              csr;
   logic                   req_valid;
   logic                   resp_valid;
   umi_pkt_t               req_pkt;
   umi_pkt_t               resp_pkt;
   logic                   req_ready;
   logic                   resp_ready;
   lumi_crdt_t             rmt_crdt;
   lumi_crdt_t             loc_crdt;
   logic [31:0]            csr_crdt_status;
   logic [`LUMI_IOW-1:0]   phy_txdata;
   logic                   phy_txvld;
   logic                   phy_txrdy;
   logic [63:0]            got_q[$];   // Beats seen on the PHY
   int                     cyc_q[$];   // Cycle of each beat
   logic [63:0]            exp_q[$];
   int                     cyc;
   int                     req_used;   // Request beats sent since reset

   tb_clkgen #(.PERIOD(CLK_NS), .RESET_CYCLES(4)) u_clkgen (.clk(clk), .nreset(nreset));

   lumi_tx u_dut
     (.clk(clk), .nreset(nreset), .csr(csr),
      .req_valid(req_valid), .resp_valid(resp_valid),
      .req_pkt(req_pkt), .resp_pkt(resp_pkt),
      .req_ready(req_ready), .resp_ready(resp_ready),
      .rmt_crdt(rmt_crdt), .loc_crdt(loc_crdt), .csr_crdt_status(csr_crdt_status),
      .phy_txdata(phy_txdata), .phy_txvld(phy_txvld), .phy_txrdy(phy_txrdy));

   //##########################################################################
   // PHY monitor, samples in the settled low phase
   //##########################################################################
   always
   begin
      @(negedge clk);
      #1;
      cyc = cyc + 1;
      if (phy_txvld && phy_txrdy)   // Transfers at the next rising edge
      begin
         got_q.push_back(phy_txdata);
         cyc_q.push_back(cyc);
      end
   end

   initial
   begin
      #(BUDGET_CYCLES*CLK_NS);
      $display("Watchdog expired before the tests finished");
      $display("TB FAILED");
      $fatal(1, "run stopped by watchdog");
   end

   task automatic check_eq(input logic [63:0] act, input logic [63:0] expv, input string what);
      if (act !== expv)
      begin
         $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, act, expv);
         $display("TB FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   //##########################################################################
   // Reference model
   //##########################################################################
   function automatic int pkt_bytes(input logic [31:0] cmd);
      int data;
      if (cmd[7:0] == `LUMI_OP_REQ_LINK || {3'b0, cmd[4:0]} == `LUMI_OP_INVALID ||
          {3'b0, cmd[4:0]} == `LUMI_OP_RESP_LINK)
         return `LUMI_CMD_BYTES;       // Header only
      case ({3'b0, cmd[4:0]})
         `LUMI_OP_REQ_READ, `LUMI_OP_REQ_RDMA, `LUMI_OP_REQ_ERROR,
         `LUMI_OP_RESP_WRITE, `LUMI_OP_REQ_USER0, `LUMI_OP_REQ_FUTURE0 :
            return `LUMI_HDR_BYTES;
         default : ;
      endcase
      data = (int'(cmd[15:8]) + 1) << cmd[7:5];
      return `LUMI_HDR_BYTES + ((data > 16) ? 16 : data);
   endfunction

   function automatic int beats_of(input logic [PKTW-1:0] p);
      return (pkt_bytes(p[31:0]) + (1 << csr.iowidth) - 1) >> csr.iowidth;
   endfunction

   // Kind 1 request, 2 response, 0 credit message
   task automatic add_beats(input logic [PKTW-1:0] p, input int kind);
      int          w;
      logic [63:0] beat;
      w = 1 << csr.iowidth;
      if (kind == 1)
         req_used += beats_of(p);
      for (int k = 0; k < beats_of(p); k++)
      begin
         beat = '0;                    // Lanes above W read zero
         for (int j = 0; j < w; j++)
            if (k*w + j < `LUMI_PKT_BYTES)
               beat[8*j +: 8] = p[8*(k*w + j) +: 8];
         exp_q.push_back(beat);
      end
   endtask

   function automatic logic [PKTW-1:0] rand_pkt(input logic [7:0] op_byte);
      logic [PKTW-1:0] p;
      for (int i = 0; i < PKTW/32; i++)
         p[32*i +: 32] = $urandom;
      p[7:0] = op_byte;                // len and upper fields stay random
      return p;
   endfunction

   function automatic logic [PKTW-1:0] crdt_msg(input logic [15:0] val, input logic [3:0] ctype);
      return {{(PKTW-32){1'b0}}, val, ctype, `LUMI_CRDT_SUBTYPE, `LUMI_CRDT_OPCODE};
   endfunction

   //##########################################################################
   // Drivers and result checks
   //##########################################################################
   task automatic send(input bit is_resp, input logic [PKTW-1:0] p);
      @(negedge clk);
      if (is_resp)
      begin
         resp_valid = 1'b1;
         resp_pkt   = p;
      end
      else
      begin
         req_valid = 1'b1;
         req_pkt   = p;
      end
      #1;
      while (!(is_resp ? resp_ready : req_ready))
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);                  // Taken at the rising edge
      if (is_resp)
         resp_valid = 1'b0;
      else
         req_valid = 1'b0;
   endtask

   task automatic clear_beats();
      got_q.delete();
      cyc_q.delete();
      exp_q.delete();
   endtask

   task automatic drain_and_compare(input string what);
      do
      begin
         @(negedge clk);
         #1;
      end
      while (got_q.size() < exp_q.size() || phy_txvld);
      check_eq(64'(got_q.size()), 64'(exp_q.size()), {what, " beat count"});
      foreach (exp_q[i])
         check_eq(got_q[i], exp_q[i], {what, " beat data"});
   endtask

   //##########################################################################
   // Tests
   //##########################################################################
   task automatic class_test();
      logic [PKTW-1:0] p;
      for (int iw = 0; iw < 4; iw++)
      begin
         @(negedge clk);
         csr.iowidth = 2'(iw);
         clear_beats();
         for (int c = 0; c < 3; c++)
         begin
            case (c)
               0       : p = rand_pkt(`LUMI_OP_REQ_LINK);
               1       : p = rand_pkt({3'($urandom), 5'(`LUMI_OP_REQ_READ)});
               default : p = rand_pkt({3'($urandom), 5'(`LUMI_OP_REQ_WRITE)});
            endcase
            add_beats(p, 1);
            send(1'b0, p);
         end
         drain_and_compare("class");
      end
   endtask

   task automatic priority_test();
      logic [PKTW-1:0] rq;
      logic [PKTW-1:0] rs;
      @(negedge clk);
      csr.iowidth = 2'd2;
      clear_beats();
      rq = rand_pkt(`LUMI_OP_REQ_WRITE);
      rs = rand_pkt(`LUMI_OP_RESP_READ);
      add_beats(rs, 2);                // Response wins
      add_beats(rq, 1);
      fork
         send(1'b1, rs);
         send(1'b0, rq);
      join
      drain_and_compare("priority");
      check_eq(64'(cyc_q[cyc_q.size()-1] - cyc_q[0] + 1), 64'(got_q.size()), "gap free");
   endtask

   task automatic credit_test();
      logic [PKTW-1:0] p;
      logic [15:0]     s0;
      logic [15:0]     r0;
      @(negedge clk);
      csr.iowidth = 2'd1;
      clear_beats();
      p = rand_pkt(`LUMI_OP_REQ_POSTED);
      rmt_crdt.req = 16'(req_used + beats_of(p) - 1);   // One short
      add_beats(p, 1);
      fork
         send(1'b0, p);
         begin
            @(negedge clk);
            #1;
            s0 = csr_crdt_status[15:0];
            r0 = csr_crdt_status[31:16];
            repeat (10)
            begin
               @(negedge clk);
               #1;
               check_eq(64'(req_ready), 64'd0, "req_ready while short");
            end
            check_eq(64'(csr_crdt_status[15:0]), 64'(s0 + 16'd10), "request stall count");
            // No response waiting, so no response stalls
            check_eq(64'(csr_crdt_status[31:16]), 64'(r0), "response stall count");
            @(negedge clk);
            rmt_crdt.req = 16'hFFFF;
         end
      join
      drain_and_compare("credit");
   endtask

   task automatic backpressure_test();
      logic [PKTW-1:0] a;
      logic [PKTW-1:0] b;
      bit              bp_on;
      @(negedge clk);
      csr.iowidth = 2'd0;
      clear_beats();
      bp_on = 1'b1;
      a = rand_pkt({3'($urandom), 5'(`LUMI_OP_REQ_ATOMIC)});
      b = rand_pkt(`LUMI_OP_RESP_READ);
      add_beats(a, 1);
      add_beats(b, 2);
      fork
         begin
            send(1'b0, a);
            send(1'b1, b);
            drain_and_compare("backpressure");
            bp_on = 1'b0;
         end
         begin
            while (bp_on)
            begin
               @(negedge clk);
               phy_txrdy = ($urandom % 3) != 0;
            end
            phy_txrdy = 1'b1;
         end
      join
   endtask

   task automatic crdt_update_test();
      logic [PKTW-1:0] p;
      @(negedge clk);
      csr.iowidth = 2'd3;
      clear_beats();
      loc_crdt.req  = 16'($urandom);
      loc_crdt.resp = 16'($urandom);
      p = rand_pkt(`LUMI_OP_REQ_READ);
      add_beats(crdt_msg(loc_crdt.resp, 4'd1), 0);   // Response count first
      add_beats(crdt_msg(loc_crdt.req, 4'd0), 0);
      add_beats(p, 1);
      fork
         send(1'b0, p);
         begin
            @(negedge clk);
            phy_txrdy        = 1'b0;    // Hold the request back
            csr.crdt_intrvl  = 16'd6;
            csr.crdt_en      = 1'b1;
            repeat (9) @(negedge clk);  // One timer wrap only
            csr.crdt_en      = 1'b0;
            repeat (2) @(negedge clk);
            phy_txrdy        = 1'b1;
         end
      join
      drain_and_compare("credit update");
   endtask

   initial
   begin
      void'($urandom(62598));
      csr         = '0;
      csr.en      = 1'b1;
      req_valid   = 1'b0;
      resp_valid  = 1'b0;
      req_pkt     = '0;
      resp_pkt    = '0;
      rmt_crdt    = '{req: 16'hFFFF, resp: 16'hFFFF};
      loc_crdt    = '0;
      phy_txrdy   = 1'b1;
      cyc         = 0;
      req_used    = 0;
      @(posedge nreset);
      class_test();
      priority_test();
      credit_test();
      backpressure_test();
      crdt_update_test();
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: lumi_tx.f
+incdir+hdl
hdl/lumi_tx_pkg.sv
hdl/lumi_pkt_size.sv
hdl/lumi_crdt_update.sv
hdl/lumi_crdt_track.sv
hdl/lumi_tx_arbiter.sv
hdl/lumi_tx_serializer.sv
hdl/lumi_tx.sv
verif/tb_clkgen.sv
verif/tb_lumi_tx.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_lumi_tx
FLIST = lumi_tx.f
BIN   = obj_dir/V$(TOP)
SRCS  = $(shell grep -v '^+' $(FLIST)) hdl/lumi_tx_consts.svh

.PHONY: run clean

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf obj_dir
